//--- include/demux_config.svh
// read demux configuration: port count, channel widths and per-ID read tracking limits
`ifndef DEMUX_CONFIG_SVH
`define DEMUX_CONFIG_SVH

// ----------------------------------------------------------------------
// topology
// ----------------------------------------------------------------------
// number of downstream (master) ports
`define DMX_NUM_PORTS 4
// port select width, enough bits to index every downstream port
`define DMX_SEL_W $clog2(`DMX_NUM_PORTS)

// ----------------------------------------------------------------------
// channel widths
// ----------------------------------------------------------------------
`define DMX_ID_W 4
`define DMX_ADDR_W 16
`define DMX_DATA_W 32
// burst length field, beats minus one
`define DMX_LEN_W 4

// ----------------------------------------------------------------------
// ID tracking
// ----------------------------------------------------------------------
// low ID bits used for ordering, one tracker per value
`define DMX_LOOK_W 2
`define DMX_NUM_TRK (1 << `DMX_LOOK_W)
// outstanding reads allowed per look-ID
`define DMX_MAX_TRANS 4
// counter must be able to hold DMX_MAX_TRANS itself
`define DMX_CNT_W $clog2(`DMX_MAX_TRANS + 1)

`endif

//--- logic/demux_pkg.sv
// shared read demux types: meaningful vector widths, AR/R channel structs, router states
`include "demux_config.svh"

package demux_pkg;

  // ----------------------------------------------------------------------
  // plain vectors
  // ----------------------------------------------------------------------
  // full transaction ID
  typedef logic [`DMX_ID_W-1:0]   id_t;
  // tracked low ID bits, selects one tracker
  typedef logic [`DMX_LOOK_W-1:0] look_id_t;
  // downstream port index
  typedef logic [`DMX_SEL_W-1:0]  port_sel_t;
  // outstanding read count of one tracker
  typedef logic [`DMX_CNT_W-1:0]  cnt_t;
  typedef logic [`DMX_ADDR_W-1:0] addr_t;
  typedef logic [`DMX_DATA_W-1:0] data_t;
  // beats minus one
  typedef logic [`DMX_LEN_W-1:0]  len_t;

  // ----------------------------------------------------------------------
  // channel structs
  // ----------------------------------------------------------------------
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } ar_chan_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    logic  last;
  } r_chan_t;

  // upstream AR together with its target port
  typedef struct packed {
    ar_chan_t  ar;
    port_sel_t sel;
  } ar_sel_t;

  // AR router: LOCKED holds an offered valid until the downstream takes it
  typedef enum logic {
    IDLE,
    LOCKED
  } route_state_e;

endpackage

//--- logic/ar_router.sv
// AR router: checks the ordering rule against the ID trackers and steers reads downstream
`timescale 1ns/1ns
`include "demux_config.svh"

module ar_router import demux_pkg::*; (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  // upstream AR
  input  ar_sel_t                          up_ar_i,
  input  logic                             up_ar_valid_i,
  output logic                             up_ar_ready_o,
  // downstream AR, payload is shared by all ports
  output ar_chan_t                         dn_ar_o,
  output logic     [`DMX_NUM_PORTS-1:0]    dn_ar_valid_o,
  input  logic     [`DMX_NUM_PORTS-1:0]    dn_ar_ready_i,
  // tracker lookup
  input  logic     [`DMX_NUM_TRK-1:0]      trk_occupied_i,
  input  logic     [`DMX_NUM_TRK-1:0]      trk_full_i,
  input  port_sel_t [`DMX_NUM_TRK-1:0]     trk_sel_i,
  // tracker push
  output logic                             push_o,
  output look_id_t                         push_id_o,
  output port_sel_t                        push_sel_o
);

  // ----------------------------------------------------------------------
  // signals
  // ----------------------------------------------------------------------
  route_state_e state_q;
  route_state_e state_d;

  // look-ID of the incoming read
  look_id_t     look_id;
  // ordering rule passes for the incoming read
  logic         route_ok;
  // valid towards the selected port, before the per-port decode
  logic         ar_valid;
  // downstream AR transfer
  logic         ar_xfer;

  // ----------------------------------------------------------------------
  // ID lookup
  // ----------------------------------------------------------------------
  assign look_id = up_ar_i.ar.id[`DMX_LOOK_W-1:0];

  // a full tracker anywhere blocks new reads, so no counter can overflow;
  // an occupied ID may only go to the port it already uses
  always_comb begin
    route_ok = 1'b0;
    if (!(|trk_full_i)) begin
      if (!trk_occupied_i[look_id] || (trk_sel_i[look_id] == up_ar_i.sel)) begin
        route_ok = 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // handshake control
  // ----------------------------------------------------------------------
  assign ar_xfer = ar_valid & dn_ar_ready_i[up_ar_i.sel];

  always_comb begin
    state_d  = state_q;
    ar_valid = 1'b0;
    case (state_q)
      IDLE: begin
        // offer in the same cycle the read arrives
        if (up_ar_valid_i && route_ok) begin
          ar_valid = 1'b1;
          // not taken yet, hold the valid whatever the trackers do
          if (!dn_ar_ready_i[up_ar_i.sel]) begin
            state_d = LOCKED;
          end
        end
      end
      LOCKED: begin
        // upstream keeps its valid and payload stable until the transfer
        ar_valid = 1'b1;
        if (dn_ar_ready_i[up_ar_i.sel]) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------------------------------------
  // outputs
  // ----------------------------------------------------------------------
  // downstream back-pressure reaches upstream directly
  assign up_ar_ready_o = ar_xfer;

  assign dn_ar_o = up_ar_i.ar;

  // valid decode, only the selected port sees it
  always_comb begin
    dn_ar_valid_o = '0;
    for (int p = 0; p < `DMX_NUM_PORTS; p++) begin
      if (ar_valid && (up_ar_i.sel == port_sel_t'(p))) begin
        dn_ar_valid_o[p] = 1'b1;
      end
    end
  end

  // count the read against its look-ID once it has left
  assign push_o     = ar_xfer;
  assign push_id_o  = look_id;
  assign push_sel_o = up_ar_i.sel;

endmodule

//--- logic/id_tracker.sv
// ID tracker: outstanding read count and target port for one look-ID value
`timescale 1ns/1ns
`include "demux_config.svh"

module id_tracker import demux_pkg::*; #(
  parameter int unsigned TRACKER_IDX = 0
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  // push from the AR router
  input  logic      push_i,
  input  look_id_t  push_id_i,
  input  port_sel_t push_sel_i,
  // pop from the R arbiter
  input  logic      pop_i,
  input  look_id_t  pop_id_i,
  // lookup results
  output logic      occupied_o,
  output logic      full_o,
  output port_sel_t sel_o
);

  cnt_t      cnt_q;
  port_sel_t sel_q;
  logic      push_hit;
  logic      pop_hit;

  // only events for this tracker's own look-ID count
  assign push_hit = push_i && (push_id_i == look_id_t'(TRACKER_IDX));
  assign pop_hit  = pop_i && (pop_id_i == look_id_t'(TRACKER_IDX));

  // push and pop together cancel out
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (push_hit && !pop_hit) begin
      cnt_q <= cnt_q + cnt_t'(1);
    end else if (pop_hit && !push_hit) begin
      cnt_q <= cnt_q - cnt_t'(1);
    end
  end

  // port of the reads in flight, only meaningful while occupied
  always_ff @(posedge clk_i) begin
    if (push_hit) begin
      sel_q <= push_sel_i;
    end
  end

  assign occupied_o = (cnt_q != '0);
  assign full_o     = (cnt_q == cnt_t'(`DMX_MAX_TRANS));
  assign sel_o      = sel_q;

endmodule

//--- logic/r_arbiter.sv
// R arbiter: round-robin merge of the downstream R channels with lock-in on offered beats
`timescale 1ns/1ns
`include "demux_config.svh"

module r_arbiter import demux_pkg::*; (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  // downstream R
  input  r_chan_t [`DMX_NUM_PORTS-1:0]   dn_r_i,
  input  logic    [`DMX_NUM_PORTS-1:0]   dn_r_valid_i,
  output logic    [`DMX_NUM_PORTS-1:0]   dn_r_ready_o,
  // upstream R
  output r_chan_t                        up_r_o,
  output logic                           up_r_valid_o,
  input  logic                           up_r_ready_i,
  // tracker pop
  output logic                           pop_o,
  output look_id_t                       pop_id_o
);

  // ----------------------------------------------------------------------
  // signals
  // ----------------------------------------------------------------------
  // last granted port, search starts one after it
  port_sel_t rr_q;
  // grant held while an offered beat waits
  logic      lock_q;
  port_sel_t gnt_q;

  port_sel_t pick;
  port_sel_t sel;
  logic      r_xfer;

  // ----------------------------------------------------------------------
  // round-robin pick
  // ----------------------------------------------------------------------
  always_comb begin
    int unsigned idx;
    logic        found;
    pick  = rr_q;
    found = 1'b0;
    // walk all ports once, the last granted one comes last
    for (int unsigned i = 1; i <= `DMX_NUM_PORTS; i++) begin
      idx = (int'(rr_q) + i) % `DMX_NUM_PORTS;
      if (!found && dn_r_valid_i[idx]) begin
        pick  = port_sel_t'(idx);
        found = 1'b1;
      end
    end
  end

  // a locked grant wins over a fresh pick
  assign sel = lock_q ? gnt_q : pick;

  // ----------------------------------------------------------------------
  // data path
  // ----------------------------------------------------------------------
  // a locked port keeps its valid up, so this never drops early
  assign up_r_valid_o = lock_q ? dn_r_valid_i[gnt_q] : (|dn_r_valid_i);
  assign up_r_o       = dn_r_i[sel];
  assign r_xfer       = up_r_valid_o & up_r_ready_i;

  // ready only to the granted port, the others wait
  always_comb begin
    dn_r_ready_o = '0;
    for (int p = 0; p < `DMX_NUM_PORTS; p++) begin
      if (r_xfer && (sel == port_sel_t'(p))) begin
        dn_r_ready_o[p] = 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // lock and pointer state
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q   <= '0;
      lock_q <= 1'b0;
      gnt_q  <= '0;
    end else begin
      if (r_xfer) begin
        // beat taken, release and move the pointer past this port
        lock_q <= 1'b0;
        rr_q   <= sel;
      end else if (up_r_valid_o) begin
        // offered but stalled
        lock_q <= 1'b1;
        gnt_q  <= sel;
      end
    end
  end

  // last beat completes the read for its look-ID
  assign pop_o    = r_xfer & up_r_o.last;
  assign pop_id_o = up_r_o.id[`DMX_LOOK_W-1:0];

endmodule

//--- logic/read_demux.sv
// read demux top: one upstream AR/R port fanned out to several downstream ports in ID order
`timescale 1ns/1ns
`include "demux_config.svh"

module read_demux import demux_pkg::*; (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  // upstream AR and R
  input  ar_sel_t                        up_ar_i,
  input  logic                           up_ar_valid_i,
  output logic                           up_ar_ready_o,
  output r_chan_t                        up_r_o,
  output logic                           up_r_valid_o,
  input  logic                           up_r_ready_i,
  // downstream AR and R
  output ar_chan_t                       dn_ar_o,
  output logic    [`DMX_NUM_PORTS-1:0]   dn_ar_valid_o,
  input  logic    [`DMX_NUM_PORTS-1:0]   dn_ar_ready_i,
  input  r_chan_t [`DMX_NUM_PORTS-1:0]   dn_r_i,
  input  logic    [`DMX_NUM_PORTS-1:0]   dn_r_valid_i,
  output logic    [`DMX_NUM_PORTS-1:0]   dn_r_ready_o
);

  // tracker state gathered for the router lookup
  logic      [`DMX_NUM_TRK-1:0] trk_occupied;
  logic      [`DMX_NUM_TRK-1:0] trk_full;
  port_sel_t [`DMX_NUM_TRK-1:0] trk_sel;

  // push from router, pop from arbiter
  logic      push;
  look_id_t  push_id;
  port_sel_t push_sel;
  logic      pop;
  look_id_t  pop_id;

  ar_router u_ar_router (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .up_ar_i        (up_ar_i),
    .up_ar_valid_i  (up_ar_valid_i),
    .up_ar_ready_o  (up_ar_ready_o),
    .dn_ar_o        (dn_ar_o),
    .dn_ar_valid_o  (dn_ar_valid_o),
    .dn_ar_ready_i  (dn_ar_ready_i),
    .trk_occupied_i (trk_occupied),
    .trk_full_i     (trk_full),
    .trk_sel_i      (trk_sel),
    .push_o         (push),
    .push_id_o      (push_id),
    .push_sel_o     (push_sel)
  );

  // one tracker per look-ID value
  for (genvar t = 0; t < `DMX_NUM_TRK; t++) begin : gen_trk
    id_tracker #(
      .TRACKER_IDX (t)
    ) u_id_tracker (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .push_i     (push),
      .push_id_i  (push_id),
      .push_sel_i (push_sel),
      .pop_i      (pop),
      .pop_id_i   (pop_id),
      .occupied_o (trk_occupied[t]),
      .full_o     (trk_full[t]),
      .sel_o      (trk_sel[t])
    );
  end

  r_arbiter u_r_arbiter (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .dn_r_i       (dn_r_i),
    .dn_r_valid_i (dn_r_valid_i),
    .dn_r_ready_o (dn_r_ready_o),
    .up_r_o       (up_r_o),
    .up_r_valid_o (up_r_valid_o),
    .up_r_ready_i (up_r_ready_i),
    .pop_o        (pop),
    .pop_id_o     (pop_id)
  );

endmodule

//--- bench/demux_checker.sv
// checker that models routing, ID ordering and handshake rules of the read demux
`timescale 1ns/1ns
`include "demux_config.svh"

module demux_checker import demux_pkg::*; (
  input logic                      clk_i,
  input logic                      arst_n_i,
  input ar_sel_t                   up_ar_i,
  input logic                      up_ar_valid_i,
  input logic                      up_ar_ready_i,
  input r_chan_t                   up_r_i,
  input logic                      up_r_valid_i,
  input logic                      up_r_ready_i,
  input ar_chan_t                  dn_ar_i,
  input logic [`DMX_NUM_PORTS-1:0] dn_ar_valid_i,
  input logic [`DMX_NUM_PORTS-1:0] dn_ar_ready_i,
  input logic [`DMX_NUM_PORTS-1:0] dn_r_valid_i,
  input logic [`DMX_NUM_PORTS-1:0] dn_r_ready_i
);

  int errors  = 0;
  int checks  = 0;
  // reads accepted upstream and not yet finished
  int pending = 0;

  // outstanding count and port per look-ID
  int        id_cnt [`DMX_NUM_TRK];
  port_sel_t id_port [`DMX_NUM_TRK];
  // expected reads per port, oldest first
  ar_chan_t  exp_q [`DMX_NUM_PORTS][$];
  len_t      exp_beat [`DMX_NUM_PORTS];
  logic      first_cycle = 1'b1;
  // offered but stalled transfers from the previous cycle
  logic      r_hold = 1'b0;
  r_chan_t   r_held;
  logic      ar_hold = 1'b0;
  logic      [`DMX_NUM_PORTS-1:0] ar_held_valid;
  ar_chan_t  ar_held;

  initial begin
    for (int i = 0; i < `DMX_NUM_TRK; i++) begin
      id_cnt[i]  = 0;
      id_port[i] = '0;
    end
    for (int i = 0; i < `DMX_NUM_PORTS; i++) begin
      exp_beat[i] = '0;
    end
  end

  task automatic report_mismatch(input string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    errors++;
  endtask

  // ----------------------------------------------------------------------
  // sampled at the falling edge, where inputs and outputs have settled
  // ----------------------------------------------------------------------
  always @(negedge clk_i) begin : watch
    look_id_t                  look;
    int                        p;
    r_chan_t                   exp_r;
    logic [`DMX_NUM_PORTS-1:0] sel_mask;
    logic [`DMX_NUM_PORTS-1:0] r_fire;
    if (!arst_n_i || first_cycle) begin
      checks++;
      if (up_ar_ready_i || (|dn_ar_valid_i) || up_r_valid_i || (|dn_r_ready_i)) begin
        report_mismatch("control output high during or right after reset");
      end
      first_cycle = !arst_n_i;
    end else begin
      if (r_hold && (!up_r_valid_i || (up_r_i != r_held))) begin
        report_mismatch("upstream R beat changed while stalled");
      end
      if (ar_hold && ((dn_ar_valid_i != ar_held_valid) || (dn_ar_i != ar_held))) begin
        report_mismatch("downstream AR changed while stalled");
      end
      sel_mask              = '0;
      sel_mask[up_ar_i.sel] = 1'b1;
      // valid only on the selected port, payload passed through unchanged
      if (|dn_ar_valid_i) begin
        checks++;
        if (!up_ar_valid_i || (dn_ar_valid_i != sel_mask) || (dn_ar_i != up_ar_i.ar)) begin
          report_mismatch("downstream AR does not match the upstream read");
        end
      end
      if ((|(dn_ar_valid_i & dn_ar_ready_i)) != (up_ar_valid_i && up_ar_ready_i)) begin
        report_mismatch("upstream and downstream AR handshakes disagree");
      end
      if (up_ar_valid_i && up_ar_ready_i) begin
        look = up_ar_i.ar.id[`DMX_LOOK_W-1:0];
        checks++;
        if ((id_cnt[look] != 0) && (id_port[look] != up_ar_i.sel)) begin
          report_mismatch($sformatf("ID %0d sent to port %0d while outstanding on port %0d",
                                    look, up_ar_i.sel, id_port[look]));
        end
        if (id_cnt[look] >= `DMX_MAX_TRANS) begin
          report_mismatch($sformatf("ID %0d accepted over the outstanding limit", look));
        end
        id_cnt[look]++;
        id_port[look] = up_ar_i.sel;
        exp_q[up_ar_i.sel].push_back(up_ar_i.ar);
        pending++;
      end
      // R beats, expected data is address plus beat index
      r_fire = dn_r_valid_i & dn_r_ready_i;
      if ((|r_fire) != (up_r_valid_i && up_r_ready_i)) begin
        report_mismatch("upstream and downstream R handshakes disagree");
      end else if (|r_fire) begin
        checks++;
        p = 0;
        for (int i = 0; i < `DMX_NUM_PORTS; i++) begin
          if (r_fire[i]) begin
            p = i;
          end
        end
        if (!$onehot(r_fire)) begin
          report_mismatch("R beat taken from more than one port");
        end else if (exp_q[p].size() == 0) begin
          report_mismatch($sformatf("R beat from port %0d with no read outstanding", p));
        end else begin
          exp_r.id   = exp_q[p][0].id;
          exp_r.data = data_t'(exp_q[p][0].addr) + data_t'(exp_beat[p]);
          exp_r.last = (exp_beat[p] == exp_q[p][0].len);
          if (up_r_i != exp_r) begin
            report_mismatch($sformatf("R beat %h, expected %h", up_r_i, exp_r));
          end
          if (exp_r.last) begin
            look = exp_r.id[`DMX_LOOK_W-1:0];
            id_cnt[look]--;
            pending--;
            exp_beat[p] = '0;
            void'(exp_q[p].pop_front());
          end else begin
            exp_beat[p] = exp_beat[p] + 1'b1;
          end
        end
      end
      r_hold        = up_r_valid_i && !up_r_ready_i;
      r_held        = up_r_i;
      ar_hold       = (|dn_ar_valid_i) && !(|(dn_ar_valid_i & dn_ar_ready_i));
      ar_held_valid = dn_ar_valid_i;
      ar_held       = dn_ar_i;
    end
  end

endmodule

//--- bench/tb_read_demux.sv
// testbench for the read demux with seeded random reads, downstream slave models and a watchdog
`timescale 1ns/1ns
`include "demux_config.svh"

module tb_read_demux import demux_pkg::*; ();

  localparam int NUM_READS  = 400;
  localparam int CLK_PERIOD = 4;
  // budget per read covers ID stalls and random back-pressure
  localparam int MAX_CYCLES = NUM_READS * 40;

  logic                         clk_i;
  logic                         arst_n_i;
  ar_sel_t                      up_ar_i;
  logic                         up_ar_valid_i;
  logic                         up_ar_ready_o;
  r_chan_t                      up_r_o;
  logic                         up_r_valid_o;
  logic                         up_r_ready_i;
  ar_chan_t                     dn_ar_o;
  logic    [`DMX_NUM_PORTS-1:0] dn_ar_valid_o;
  logic    [`DMX_NUM_PORTS-1:0] dn_ar_ready_i;
  r_chan_t [`DMX_NUM_PORTS-1:0] dn_r_i;
  logic    [`DMX_NUM_PORTS-1:0] dn_r_valid_i;
  logic    [`DMX_NUM_PORTS-1:0] dn_r_ready_o;

  integer   seed;
  int       sent;
  int       bench_errors;
  // handshakes seen before the coming edge
  logic     ar_taken;
  logic     [`DMX_NUM_PORTS-1:0] ar_fire;
  logic     [`DMX_NUM_PORTS-1:0] r_fire;
  ar_chan_t ar_req;
  // reads held by each slave model and the next beat of its oldest read
  ar_chan_t slv_q [`DMX_NUM_PORTS][$];
  len_t     beat [`DMX_NUM_PORTS];

  read_demux dut (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .up_ar_i       (up_ar_i),
    .up_ar_valid_i (up_ar_valid_i),
    .up_ar_ready_o (up_ar_ready_o),
    .up_r_o        (up_r_o),
    .up_r_valid_o  (up_r_valid_o),
    .up_r_ready_i  (up_r_ready_i),
    .dn_ar_o       (dn_ar_o),
    .dn_ar_valid_o (dn_ar_valid_o),
    .dn_ar_ready_i (dn_ar_ready_i),
    .dn_r_i        (dn_r_i),
    .dn_r_valid_i  (dn_r_valid_i),
    .dn_r_ready_o  (dn_r_ready_o)
  );

  demux_checker u_checker (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .up_ar_i       (up_ar_i),
    .up_ar_valid_i (up_ar_valid_i),
    .up_ar_ready_i (up_ar_ready_o),
    .up_r_i        (up_r_o),
    .up_r_valid_i  (up_r_valid_o),
    .up_r_ready_i  (up_r_ready_i),
    .dn_ar_i       (dn_ar_o),
    .dn_ar_valid_i (dn_ar_valid_o),
    .dn_ar_ready_i (dn_ar_ready_i),
    .dn_r_valid_i  (dn_r_valid_i),
    .dn_r_ready_i  (dn_r_ready_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  task automatic drive_upstream();
    if (ar_taken) begin
      up_ar_valid_i = 1'b0;
      sent++;
    end
    // new read only once the previous one has been taken
    if (!up_ar_valid_i && (sent < NUM_READS) && (($random(seed) & 1) != 0)) begin
      up_ar_i.ar.id   = id_t'($random(seed));
      up_ar_i.ar.addr = addr_t'($random(seed));
      up_ar_i.ar.len  = len_t'($random(seed) & 3);
      up_ar_i.sel     = port_sel_t'($random(seed));
      up_ar_valid_i   = 1'b1;
    end
    up_r_ready_i = (($random(seed) & 3) != 0);
  endtask

  task automatic drive_slaves();
    for (int p = 0; p < `DMX_NUM_PORTS; p++) begin
      if (ar_fire[p]) begin
        slv_q[p].push_back(ar_req);
      end
      if (r_fire[p]) begin
        // oldest read finished with this beat
        if (dn_r_i[p].last) begin
          void'(slv_q[p].pop_front());
          beat[p] = '0;
        end else begin
          beat[p] = beat[p] + 1'b1;
        end
        dn_r_valid_i[p] = 1'b0;
      end
      if (!dn_r_valid_i[p] && (slv_q[p].size() != 0) && (($random(seed) & 1) != 0)) begin
        dn_r_i[p].id    = slv_q[p][0].id;
        dn_r_i[p].data  = data_t'(slv_q[p][0].addr) + data_t'(beat[p]);
        dn_r_i[p].last  = (beat[p] == slv_q[p][0].len);
        dn_r_valid_i[p] = 1'b1;
      end
      dn_ar_ready_i[p] = (($random(seed) & 1) != 0);
    end
  endtask

  task automatic end_run(input bit timed_out);
    int total;
    total = u_checker.errors + bench_errors;
    $display("checks %0d, errors %0d, reads sent %0d", u_checker.checks, total, sent);
    if (timed_out || (total != 0)) begin
      $display("** FAIL **");
    end else begin
      $display("** PASS **");
    end
    $finish;
  endtask

  initial begin
    seed          = 75303;
    clk_i         = 1'b0;
    arst_n_i      = 1'b0;
    up_ar_i       = '0;
    up_ar_valid_i = 1'b0;
    up_r_ready_i  = 1'b0;
    dn_ar_ready_i = '0;
    dn_r_i        = '0;
    dn_r_valid_i  = '0;
    sent          = 0;
    bench_errors  = 0;
    ar_taken      = 1'b0;
    ar_fire       = '0;
    r_fire        = '0;
    ar_req        = '0;
    for (int p = 0; p < `DMX_NUM_PORTS; p++) begin
      beat[p] = '0;
    end
    repeat (5) @(posedge clk_i);
    #1 arst_n_i = 1'b1;
    // one quiet cycle so the outputs right after reset stay idle
    @(posedge clk_i);
    while ((sent < NUM_READS) || (u_checker.pending != 0)) begin
      #1;
      drive_upstream();
      drive_slaves();
      // sample where everything has settled for the coming edge
      @(negedge clk_i);
      ar_taken = up_ar_valid_i && up_ar_ready_o;
      ar_fire  = dn_ar_valid_o & dn_ar_ready_i;
      r_fire   = dn_r_valid_i & dn_r_ready_o;
      ar_req   = dn_ar_o;
      @(posedge clk_i);
    end
    // retire the final beat in the slave models
    #1;
    drive_upstream();
    drive_slaves();
    for (int p = 0; p < `DMX_NUM_PORTS; p++) begin
      if ((slv_q[p].size() != 0) || dn_r_valid_i[p]) begin
        $display("slave model on port %0d still holds reads at the end of the run", p);
        bench_errors++;
      end
    end
    end_run(1'b0);
  end

  // watchdog
  initial begin
    #(MAX_CYCLES * CLK_PERIOD);
    $display("timeout, reads still outstanding after %0d cycles", MAX_CYCLES);
    end_run(1'b1);
  end

endmodule

//--- compile.f
+incdir+include
logic/demux_pkg.sv
logic/ar_router.sv
logic/id_tracker.sv
logic/r_arbiter.sv
logic/read_demux.sv
bench/demux_checker.sv
bench/tb_read_demux.sv

//--- run.sh
#!/bin/sh
# build and run the read demux testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_read_demux -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qxF '** PASS **' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
